// ==== mult_width_pkg.sv ====
package mult_width_pkg;

  // operand byte and digit split
  localparam int OPERAND_W = 8;
  localparam int DIGIT_W = 2;
  localparam int NUM_DIGITS = OPERAND_W / DIGIT_W;

  // unsigned 2-bit digit times signed 2-bit digit needs 5 bits
  localparam int DIGIT_PROD_W = 5;

  // one 4x4 block of digits after shift and add
  localparam int GROUP_W = 12;

  // lane result widths
  localparam int PROD_WIDE_W = 17;
  localparam int PROD_MID_W = 9;
  localparam int PROD_NARROW_W = 4;

  // data byte or weight byte
  typedef logic [OPERAND_W-1:0] operand_t;

  // single digit product, always treated as signed
  typedef logic signed [DIGIT_PROD_W-1:0] digit_prod_t;

  // [column][row], column is the data digit and row the weight digit
  typedef digit_prod_t [NUM_DIGITS-1:0][NUM_DIGITS-1:0] digit_grid_t;

  typedef logic signed [GROUP_W-1:0] group_sum_t;

  // lane 0 carries the full 8x8 product
  typedef logic signed [PROD_WIDE_W-1:0] prod_wide_t;
  // lane 1 holds at most a 4x4 product
  typedef logic signed [PROD_MID_W-1:0] prod_mid_t;
  // lanes 2 and 3 only ever hold a 2x2 product
  typedef logic signed [PROD_NARROW_W-1:0] prod_narrow_t;

endpackage

// ==== mult_mode_pkg.sv ====
package mult_mode_pkg;

  // precision select at the top level
  // code 3 is reserved and runs as 2x2
  typedef enum logic [1:0] {
    MODE_8X8  = 2'd0,
    MODE_4X4  = 2'd1,
    MODE_2X2  = 2'd2,
    MODE_RSVD = 2'd3
  } mode_t;

  // which weight byte feeds each data column
  typedef enum logic [1:0] {
    // w1 on every column
    ROUTE_ALL_W1,
    // w1 on columns 0 and 1, w2 on columns 2 and 3
    ROUTE_PAIRS,
    // weight k+1 on column k
    ROUTE_EACH
  } route_t;

  // how the group stage builds its four sums
  typedef enum logic {
    // shifted 2x2 blocks of digit products
    GROUP_BLOCKS,
    // one row-0 digit product per group
    GROUP_LANES
  } group_form_t;

  // how the group sums map onto the lane outputs
  typedef enum logic [1:0] {
    COMBINE_FULL,
    COMBINE_TWO,
    COMBINE_FOUR
  } combine_form_t;

endpackage

// ==== mult_bus_if.sv ====
// per-stage control decoded from the mode
interface mult_ctrl_if;

  // bit j marks weight digit row j as the signed top digit
  logic [mult_width_pkg::NUM_DIGITS-1:0] sign_rows;
  mult_mode_pkg::route_t route;
  mult_mode_pkg::group_form_t group_form;
  // follows the registered mode, one cycle behind the others
  mult_mode_pkg::combine_form_t combine_form;

  modport ctrl (
    output sign_rows,
    output route,
    output group_form,
    output combine_form
  );

  modport array (
    input sign_rows,
    input route
  );

  modport group (
    input group_form
  );

  modport combine (
    input combine_form
  );

endinterface

// registered group sums between the two pipeline stages
interface group_bus_if;

  mult_width_pkg::group_sum_t g0;
  mult_width_pkg::group_sum_t g1;
  mult_width_pkg::group_sum_t g2;
  mult_width_pkg::group_sum_t g3;

  modport src (
    output g0,
    output g1,
    output g2,
    output g3
  );

  modport dst (
    input g0,
    input g1,
    input g2,
    input g3
  );

endinterface

// ==== precision_control.sv ====
module precision_control (
  input  logic                 clk,
  input  logic                 rst,
  input  mult_mode_pkg::mode_t mode,
  mult_ctrl_if.ctrl            ctrl
);

  // mode of the item now in the group register
  mult_mode_pkg::mode_t mode_q;

  // first stage control comes straight from the input mode
  always_comb
  begin
    case (mode)
      mult_mode_pkg::MODE_8X8:
      begin
        ctrl.route = mult_mode_pkg::ROUTE_ALL_W1;
        // only the top digit of w1 carries sign
        ctrl.sign_rows = 4'b1000;
        ctrl.group_form = mult_mode_pkg::GROUP_BLOCKS;
      end
      mult_mode_pkg::MODE_4X4:
      begin
        ctrl.route = mult_mode_pkg::ROUTE_PAIRS;
        // digit 1 is the top of the low weight nibble
        ctrl.sign_rows = 4'b0010;
        ctrl.group_form = mult_mode_pkg::GROUP_BLOCKS;
      end
      default:
      begin
        // 2x2 and reserved
        ctrl.route = mult_mode_pkg::ROUTE_EACH;
        ctrl.sign_rows = 4'b0001;
        ctrl.group_form = mult_mode_pkg::GROUP_LANES;
      end
    endcase
  end

  // mode travels with its item into the second stage
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mode_q <= mult_mode_pkg::MODE_8X8;
    end
    else if (mode == mult_mode_pkg::MODE_RSVD)
    begin
      // reserved folds into 2x2 here
      mode_q <= mult_mode_pkg::MODE_2X2;
    end
    else
    begin
      mode_q <= mode;
    end
  end

  // combine control from the registered copy
  always_comb
  begin
    case (mode_q)
      mult_mode_pkg::MODE_8X8:
      begin
        ctrl.combine_form = mult_mode_pkg::COMBINE_FULL;
      end
      mult_mode_pkg::MODE_4X4:
      begin
        ctrl.combine_form = mult_mode_pkg::COMBINE_TWO;
      end
      default:
      begin
        ctrl.combine_form = mult_mode_pkg::COMBINE_FOUR;
      end
    endcase
  end

endmodule

// ==== digit_multiplier_array.sv ====
module digit_multiplier_array (
  input  mult_width_pkg::operand_t    d,
  input  mult_width_pkg::operand_t    w1,
  input  mult_width_pkg::operand_t    w2,
  input  mult_width_pkg::operand_t    w3,
  input  mult_width_pkg::operand_t    w4,
  mult_ctrl_if.array                  ctrl,
  output mult_width_pkg::digit_grid_t digits
);

  localparam int DW = mult_width_pkg::DIGIT_W;
  localparam int ND = mult_width_pkg::NUM_DIGITS;
  localparam int PW = mult_width_pkg::DIGIT_PROD_W;

  // weight byte seen by each data column
  mult_width_pkg::operand_t col_w [ND];

  always_comb
  begin
    case (ctrl.route)
      mult_mode_pkg::ROUTE_ALL_W1:
      begin
        col_w[0] = w1;
        col_w[1] = w1;
        col_w[2] = w1;
        col_w[3] = w1;
      end
      mult_mode_pkg::ROUTE_PAIRS:
      begin
        // low nibble of d against w1, high nibble against w2
        col_w[0] = w1;
        col_w[1] = w1;
        col_w[2] = w2;
        col_w[3] = w2;
      end
      default:
      begin
        // one weight per data digit
        col_w[0] = w1;
        col_w[1] = w2;
        col_w[2] = w3;
        col_w[3] = w4;
      end
    endcase
  end

  // sixteen 2x2 cells, column c by row j
  for (genvar c = 0; c < ND; c++)
  begin : g_col
    for (genvar j = 0; j < ND; j++)
    begin : g_row
      logic [DW-1:0] d_dig;
      logic [DW-1:0] w_dig;
      logic signed [PW-1:0] d_ext;
      logic signed [PW-1:0] w_ext;

      assign d_dig = d[DW*c +: DW];
      assign w_dig = col_w[c][DW*j +: DW];

      // data digit is always unsigned
      assign d_ext = {{(PW-DW){1'b0}}, d_dig};

      // weight digit signed only on the top row of its lane
      assign w_ext = ctrl.sign_rows[j] ? {{(PW-DW){w_dig[DW-1]}}, w_dig}
                                       : {{(PW-DW){1'b0}}, w_dig};

      // range is -6 to 9, fits the 5-bit product
      assign digits[c][j] = d_ext * w_ext;
    end
  end

endmodule

// ==== group_sum_stage.sv ====
module group_sum_stage (
  input  logic                        clk,
  input  logic                        rst,
  input  mult_width_pkg::digit_grid_t digits,
  mult_ctrl_if.group                  ctrl,
  group_bus_if.src                    grp
);

  localparam int DW = mult_width_pkg::DIGIT_W;
  localparam int NG = mult_width_pkg::NUM_DIGITS;

  // shifted sum of one 2x2 block
  // pXY is column offset X and row offset Y inside the block
  function automatic mult_width_pkg::group_sum_t block_sum(
    input mult_width_pkg::digit_prod_t p00,
    input mult_width_pkg::digit_prod_t p10,
    input mult_width_pkg::digit_prod_t p01,
    input mult_width_pkg::digit_prod_t p11
  );
    mult_width_pkg::group_sum_t acc;
    acc = mult_width_pkg::group_sum_t'(p00);
    acc = acc + (mult_width_pkg::group_sum_t'(p10) <<< DW);
    acc = acc + (mult_width_pkg::group_sum_t'(p01) <<< DW);
    acc = acc + (mult_width_pkg::group_sum_t'(p11) <<< (2 * DW));
    return acc;
  endfunction

  mult_width_pkg::group_sum_t blk_sum [NG];
  mult_width_pkg::group_sum_t lane_sum [NG];
  mult_width_pkg::group_sum_t sum_nxt [NG];

  // group b covers columns cb..cb+1 and rows rb..rb+1
  // g0 low/low, g1 low data with high weight, g2 high/low, g3 high/high
  for (genvar b = 0; b < NG; b++)
  begin : g_group
    localparam int CB = (b / 2) * 2;
    localparam int RB = (b % 2) * 2;

    assign blk_sum[b] = block_sum(digits[CB][RB], digits[CB+1][RB],
                                  digits[CB][RB+1], digits[CB+1][RB+1]);

    // 2x2 lanes only need the row-0 cell of their own column
    assign lane_sum[b] = mult_width_pkg::group_sum_t'($signed(digits[b][0]));

    assign sum_nxt[b] = (ctrl.group_form == mult_mode_pkg::GROUP_BLOCKS) ? blk_sum[b]
                                                                         : lane_sum[b];
  end

  // first pipeline register
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grp.g0 <= '0;
      grp.g1 <= '0;
      grp.g2 <= '0;
      grp.g3 <= '0;
    end
    else
    begin
      grp.g0 <= sum_nxt[0];
      grp.g1 <= sum_nxt[1];
      grp.g2 <= sum_nxt[2];
      grp.g3 <= sum_nxt[3];
    end
  end

endmodule

// ==== lane_combine_stage.sv ====
module lane_combine_stage (
  input  logic                          clk,
  input  logic                          rst,
  mult_ctrl_if.combine                  ctrl,
  group_bus_if.dst                      grp,
  output mult_width_pkg::prod_wide_t    prod1,
  output mult_width_pkg::prod_mid_t     prod2,
  output mult_width_pkg::prod_narrow_t  prod3,
  output mult_width_pkg::prod_narrow_t  prod4
);

  // shift of one nibble in the full product
  localparam int NIB = 2 * mult_width_pkg::DIGIT_W;

  mult_width_pkg::prod_wide_t full_sum;
  mult_width_pkg::prod_wide_t prod1_nxt;
  mult_width_pkg::prod_mid_t prod2_nxt;
  mult_width_pkg::prod_narrow_t prod3_nxt;
  mult_width_pkg::prod_narrow_t prod4_nxt;

  // 8x8 recombination
  // g1 and g2 sit one nibble up, g3 two nibbles up
  assign full_sum = mult_width_pkg::prod_wide_t'(grp.g0)
                  + (mult_width_pkg::prod_wide_t'(grp.g1) <<< NIB)
                  + (mult_width_pkg::prod_wide_t'(grp.g2) <<< NIB)
                  + (mult_width_pkg::prod_wide_t'(grp.g3) <<< (2 * NIB));

  always_comb
  begin
    prod1_nxt = '0;
    prod2_nxt = '0;
    prod3_nxt = '0;
    prod4_nxt = '0;
    case (ctrl.combine_form)
      mult_mode_pkg::COMBINE_FULL:
      begin
        prod1_nxt = full_sum;
      end
      mult_mode_pkg::COMBINE_TWO:
      begin
        // two 4x4 lanes, g1 and g3 unused
        prod1_nxt = mult_width_pkg::prod_wide_t'(grp.g0);
        prod2_nxt = mult_width_pkg::prod_mid_t'(grp.g2);
      end
      default:
      begin
        // four 2x2 lanes
        // narrow lanes truncate, value already fits
        prod1_nxt = mult_width_pkg::prod_wide_t'(grp.g0);
        prod2_nxt = mult_width_pkg::prod_mid_t'(grp.g1);
        prod3_nxt = mult_width_pkg::prod_narrow_t'(grp.g2);
        prod4_nxt = mult_width_pkg::prod_narrow_t'(grp.g3);
      end
    endcase
  end

  // output register
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      prod1 <= '0;
      prod2 <= '0;
      prod3 <= '0;
      prod4 <= '0;
    end
    else
    begin
      prod1 <= prod1_nxt;
      prod2 <= prod2_nxt;
      prod3 <= prod3_nxt;
      prod4 <= prod4_nxt;
    end
  end

endmodule

// ==== reconfig_multiplier.sv ====
module reconfig_multiplier (
  input  logic        clk,
  input  logic        rst,
  input  logic [1:0]  mode,
  input  logic [7:0]  d,
  input  logic [7:0]  w1,
  input  logic [7:0]  w2,
  input  logic [7:0]  w3,
  input  logic [7:0]  w4,
  output logic [16:0] prod1,
  output logic [8:0]  prod2,
  output logic [3:0]  prod3,
  output logic [3:0]  prod4
);

  // stage control and registered group sums
  mult_ctrl_if ctrl_bus ();
  group_bus_if grp_bus ();

  // combinational digit products into the group stage
  mult_width_pkg::digit_grid_t digit_grid;

  precision_control precision_control_inst (
    .clk  (clk),
    .rst  (rst),
    .mode (mult_mode_pkg::mode_t'(mode)),
    .ctrl (ctrl_bus.ctrl)
  );

  digit_multiplier_array digit_multiplier_array_inst (
    .d      (d),
    .w1     (w1),
    .w2     (w2),
    .w3     (w3),
    .w4     (w4),
    .ctrl   (ctrl_bus.array),
    .digits (digit_grid)
  );

  // loaded at the edge that samples the inputs
  group_sum_stage group_sum_stage_inst (
    .clk    (clk),
    .rst    (rst),
    .digits (digit_grid),
    .ctrl   (ctrl_bus.group),
    .grp    (grp_bus.src)
  );

  // loaded one edge later
  lane_combine_stage lane_combine_stage_inst (
    .clk   (clk),
    .rst   (rst),
    .ctrl  (ctrl_bus.combine),
    .grp   (grp_bus.dst),
    .prod1 (prod1),
    .prod2 (prod2),
    .prod3 (prod3),
    .prod4 (prod4)
  );

endmodule

// ==== tb_reconfig_multiplier.sv ====
module tb_reconfig_multiplier;

  localparam int NUM_ROWS = 64;
  localparam int NUM_CORNER = 8;
  localparam int RESET_LIMIT = 40;
  localparam int DRAIN_LIMIT = 8;

  // one table row, stimulus then expected lane results
  typedef struct packed {
    mult_mode_pkg::mode_t mode;
    mult_width_pkg::operand_t d;
    mult_width_pkg::operand_t w1;
    mult_width_pkg::operand_t w2;
    mult_width_pkg::operand_t w3;
    mult_width_pkg::operand_t w4;
    mult_width_pkg::prod_wide_t exp1;
    mult_width_pkg::prod_mid_t exp2;
    mult_width_pkg::prod_narrow_t exp3;
    mult_width_pkg::prod_narrow_t exp4;
  } stim_row_t;

  logic clk = 1'b0;
  // held from time zero so the reset wait sees it set
  logic rst = 1'b1;
  mult_mode_pkg::mode_t mode;
  mult_width_pkg::operand_t d;
  mult_width_pkg::operand_t w1;
  mult_width_pkg::operand_t w2;
  mult_width_pkg::operand_t w3;
  mult_width_pkg::operand_t w4;
  mult_width_pkg::prod_wide_t prod1;
  mult_width_pkg::prod_mid_t prod2;
  mult_width_pkg::prod_narrow_t prod3;
  mult_width_pkg::prod_narrow_t prod4;

  stim_row_t table_rows [NUM_ROWS];
  // row indices still in the pipeline
  int in_flight [$];

  reconfig_multiplier reconfig_multiplier_inst (
    .clk   (clk),
    .rst   (rst),
    .mode  (mode),
    .d     (d),
    .w1    (w1),
    .w2    (w2),
    .w3    (w3),
    .w4    (w4),
    .prod1 (prod1),
    .prod2 (prod2),
    .prod3 (prod3),
    .prod4 (prod4)
  );

  always #5 clk = ~clk;

  initial
  begin
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  end

  // lane rules straight from the precision definitions
  function automatic stim_row_t add_expected(input stim_row_t r);
    stim_row_t res;
    int dv;
    int wv;
    res = r;
    res.exp1 = '0;
    res.exp2 = '0;
    res.exp3 = '0;
    res.exp4 = '0;
    case (r.mode)
      mult_mode_pkg::MODE_8X8:
      begin
        dv = r.d;
        wv = $signed(r.w1);
        res.exp1 = mult_width_pkg::prod_wide_t'(dv * wv);
      end
      mult_mode_pkg::MODE_4X4:
      begin
        // upper weight nibbles play no part
        dv = r.d[3:0];
        wv = $signed(r.w1[3:0]);
        res.exp1 = mult_width_pkg::prod_wide_t'(dv * wv);
        dv = r.d[7:4];
        wv = $signed(r.w2[3:0]);
        res.exp2 = mult_width_pkg::prod_mid_t'(dv * wv);
      end
      default:
      begin
        // 2x2 and reserved, digit k times low two bits of weight k+1
        dv = r.d[1:0];
        wv = $signed(r.w1[1:0]);
        res.exp1 = mult_width_pkg::prod_wide_t'(dv * wv);
        dv = r.d[3:2];
        wv = $signed(r.w2[1:0]);
        res.exp2 = mult_width_pkg::prod_mid_t'(dv * wv);
        dv = r.d[5:4];
        wv = $signed(r.w3[1:0]);
        res.exp3 = mult_width_pkg::prod_narrow_t'(dv * wv);
        dv = r.d[7:6];
        wv = $signed(r.w4[1:0]);
        res.exp4 = mult_width_pkg::prod_narrow_t'(dv * wv);
      end
    endcase
    return res;
  endfunction

  task automatic set_row(input int idx, input mult_mode_pkg::mode_t m,
                         input logic [7:0] dd, input logic [7:0] a, input logic [7:0] b,
                         input logic [7:0] c, input logic [7:0] e);
    stim_row_t r;
    r = '0;
    r.mode = m;
    r.d = dd;
    r.w1 = a;
    r.w2 = b;
    r.w3 = c;
    r.w4 = e;
    table_rows[idx] = add_expected(r);
  endtask

  task automatic check_wide(input string lane, input mult_width_pkg::prod_wide_t exp,
                            input mult_width_pkg::prod_wide_t act);
    if (act !== exp)
    begin
      $display("ERROR: %0t: %s expected %0d, actual %0d", $time, lane, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "lane output mismatch");
    end
  endtask

  task automatic check_mid(input string lane, input mult_width_pkg::prod_mid_t exp,
                           input mult_width_pkg::prod_mid_t act);
    if (act !== exp)
    begin
      $display("ERROR: %0t: %s expected %0d, actual %0d", $time, lane, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "lane output mismatch");
    end
  endtask

  task automatic check_narrow(input string lane, input mult_width_pkg::prod_narrow_t exp,
                              input mult_width_pkg::prod_narrow_t act);
    if (act !== exp)
    begin
      $display("ERROR: %0t: %s expected %0d, actual %0d", $time, lane, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "lane output mismatch");
    end
  endtask

  task automatic check_row(input int idx);
    check_wide("prod1", table_rows[idx].exp1, prod1);
    check_mid("prod2", table_rows[idx].exp2, prod2);
    check_narrow("prod3", table_rows[idx].exp3, prod3);
    check_narrow("prod4", table_rows[idx].exp4, prod4);
  endtask

  task automatic apply_row(input int idx);
    mode <= table_rows[idx].mode;
    d <= table_rows[idx].d;
    w1 <= table_rows[idx].w1;
    w2 <= table_rows[idx].w2;
    w3 <= table_rows[idx].w3;
    w4 <= table_rows[idx].w4;
  endtask

  initial
  begin
    int cycles;
    // nonzero operands while reset holds the pipeline
    mode = mult_mode_pkg::MODE_8X8;
    d = 8'hff;
    w1 = 8'h80;
    w2 = 8'h7f;
    w3 = 8'h55;
    w4 = 8'haa;
    void'($urandom(76342));

    // corners, 8x8 extremes and zeros first
    set_row(0, mult_mode_pkg::MODE_8X8, 8'hff, 8'h80, 8'h00, 8'h00, 8'h00);
    set_row(1, mult_mode_pkg::MODE_8X8, 8'hff, 8'h7f, 8'h00, 8'h00, 8'h00);
    set_row(2, mult_mode_pkg::MODE_8X8, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
    // 4x4 with junk in the upper weight nibbles
    set_row(3, mult_mode_pkg::MODE_4X4, 8'hff, 8'hf8, 8'h37, 8'hff, 8'hff);
    set_row(4, mult_mode_pkg::MODE_4X4, 8'h5a, 8'h97, 8'hc9, 8'h12, 8'h34);
    // -2 times 3 on lane 0, reserved repeats the same operands
    set_row(5, mult_mode_pkg::MODE_2X2, 8'hff, 8'hfe, 8'h01, 8'hff, 8'h02);
    set_row(6, mult_mode_pkg::MODE_RSVD, 8'hff, 8'hfe, 8'h01, 8'hff, 8'h02);
    set_row(7, mult_mode_pkg::MODE_2X2, 8'he4, 8'h01, 8'h02, 8'h03, 8'hfd);
    // first half cycles the modes row by row, second half random modes
    for (int i = NUM_CORNER; i < NUM_ROWS; i++)
    begin
      set_row(i, (i < NUM_ROWS / 2) ? mult_mode_pkg::mode_t'(i % 4)
                                    : mult_mode_pkg::mode_t'($urandom_range(0, 3)),
              8'($urandom), 8'($urandom), 8'($urandom), 8'($urandom), 8'($urandom));
    end

    cycles = 0;
    while (rst)
    begin
      if (cycles >= RESET_LIMIT)
      begin
        $display("timed out waiting for reset release");
        $display("RESULT: FAIL");
        $fatal(1, "reset wait overrun");
      end
      @(negedge clk);
      cycles++;
    end

    // outputs still cleared right after release
    check_wide("prod1", '0, prod1);
    check_mid("prod2", '0, prod2);
    check_narrow("prod3", '0, prod3);
    check_narrow("prod4", '0, prod4);

    // row driven at edge k shows just after edge k+2
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      @(posedge clk);
      apply_row(i);
      in_flight.push_back(i);
      @(negedge clk);
      if (in_flight.size() > 2)
      begin
        check_row(in_flight.pop_front());
      end
    end

    cycles = 0;
    while (in_flight.size() > 0)
    begin
      if (cycles >= DRAIN_LIMIT)
      begin
        $display("timed out draining the pipeline");
        $display("RESULT: FAIL");
        $fatal(1, "drain wait overrun");
      end
      @(negedge clk);
      check_row(in_flight.pop_front());
      cycles++;
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== vlog.f ====
mult_width_pkg.sv
mult_mode_pkg.sv
mult_bus_if.sv
precision_control.sv
digit_multiplier_array.sv
group_sum_stage.sv
lane_combine_stage.sv
reconfig_multiplier.sv
tb_reconfig_multiplier.sv
